//--- hdl/matrix_rank_defs.svh
/*
 * Sizing macros for the matrix rank subsystem
 * Element width, matrix bounds, index widths, multiplier length
 */
`ifndef MATRIX_RANK_DEFS_SVH
`define MATRIX_RANK_DEFS_SVH

// Element, modulus and rank width
`define MR_DATA_W 16

// Largest row or column count
`define MR_MAX_DIM 4

// Row or column index, and a count of 1 to 4
`define MR_IDX_W 2
`define MR_DIM_W 3

// One multiplier iteration per operand bit
`define MR_MUL_CYCLES `MR_DATA_W

`endif

//--- hdl/mr_arith_pkg.sv
/*
 * Vector types shared by the arithmetic blocks and the element store
 * Residues, indices, dimension counts and the pivot row mask
 */
`include "matrix_rank_defs.svh"

package mr_arith_pkg;

  // Residue, modulus or rank
  typedef logic [`MR_DATA_W-1:0] value_t;

  // Row or column address into the store
  typedef logic [`MR_IDX_W-1:0] idx_t;

  // Dimension count, 1 to MR_MAX_DIM
  typedef logic [`MR_DIM_W-1:0] dim_t;

  // One bit per row, set once the row has served as pivot
  typedef logic [`MR_MAX_DIM-1:0] row_mask_t;

endpackage

//--- hdl/mr_ctrl_pkg.sv
/*
 * State encodings for the elimination controller
 * and the serial modular multiplier
 */

package mr_ctrl_pkg;

  // Elimination controller
  typedef enum logic [3:0] {
    ST_IDLE, ST_LOAD, ST_FIND_PIVOT, ST_CHECK_ROW, ST_MUL_A,
    ST_MUL_B, ST_SUBTRACT, ST_WRITE, ST_NEXT_COL, ST_DONE
  } rank_state_t;

  // Double-and-add multiplier
  typedef enum logic {
    MUL_IDLE,
    MUL_RUN
  } mul_state_t;

endpackage

//--- hdl/mod_adder.sv
/*
 * Modular adder/subtractor, one cycle from start to ready
 * Operands already reduced, one conditional correction step
 */
`timescale 1ns/1ps
`include "matrix_rank_defs.svh"

module mod_adder (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  logic                 operation,
  input  mr_arith_pkg::value_t modulo,
  input  mr_arith_pkg::value_t data_a,
  input  mr_arith_pkg::value_t data_b,
  output logic                 ready,
  output mr_arith_pkg::value_t data_out
);
  import mr_arith_pkg::*;

  // Extra top bit holds carry or borrow
  logic [`MR_DATA_W:0] raw;
  logic [`MR_DATA_W:0] fixed;
  value_t              result;

  always_comb begin
    if (operation) begin
      raw = {1'b0, data_a} - {1'b0, data_b};
      // Borrow set means a < b, so fold back by one modulus
      fixed = raw + {1'b0, modulo};
      result = raw[`MR_DATA_W] ? fixed[`MR_DATA_W-1:0] : raw[`MR_DATA_W-1:0];
    end else begin
      raw = {1'b0, data_a} + {1'b0, data_b};
      fixed = raw - {1'b0, modulo};
      result = (raw >= {1'b0, modulo}) ? fixed[`MR_DATA_W-1:0] : raw[`MR_DATA_W-1:0];
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ready <= 1'b0;
    end else begin
      ready <= start;
    end
  end

  // Result register, held until the next request
  always_ff @(posedge CLK) begin
    if (start) begin
      data_out <= result;
    end
  end

  // Answer arrives next cycle and is already below the modulus
  assert property (@(posedge CLK) disable iff (RST)
    start |=> ready && (data_out < $past(modulo)));

endmodule

//--- hdl/mod_multiplier.sv
/*
 * Serial modular multiplier, MSB-first double-and-add
 * Ready exactly MR_MUL_CYCLES+1 cycles after start
 */
`timescale 1ns/1ps
`include "matrix_rank_defs.svh"

module mod_multiplier (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  mr_arith_pkg::value_t modulo,
  input  mr_arith_pkg::value_t data_a,
  input  mr_arith_pkg::value_t data_b,
  output logic                 ready,
  output mr_arith_pkg::value_t data_out
);
  import mr_arith_pkg::*;
  import mr_ctrl_pkg::*;

  localparam int CNT_W = $clog2(`MR_MUL_CYCLES);

  mul_state_t          state;
  logic [CNT_W-1:0]    bit_cnt;
  logic                last;
  value_t              mod_q;
  value_t              a_q;
  value_t              b_q;
  value_t              acc;
  logic [`MR_DATA_W:0] dbl;
  value_t              dbl_red;
  logic [`MR_DATA_W:0] sum;
  value_t              acc_next;

  ////////////////////
  // One step per bit
  ////////////////////

  always_comb begin
    // acc*2, folded once
    dbl = {acc, 1'b0};
    dbl_red = (dbl >= {1'b0, mod_q}) ? dbl[`MR_DATA_W-1:0] - mod_q : dbl[`MR_DATA_W-1:0];
    // Add multiplicand when current bit of b is set
    sum = {1'b0, dbl_red} + (b_q[`MR_DATA_W-1] ? {1'b0, a_q} : '0);
    acc_next = (sum >= {1'b0, mod_q}) ? sum[`MR_DATA_W-1:0] - mod_q : sum[`MR_DATA_W-1:0];
  end

  assign last = (bit_cnt == CNT_W'(`MR_MUL_CYCLES - 1));

  ////////////////////
  // Sequencing
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= MUL_IDLE;
      bit_cnt <= '0;
      ready <= 1'b0;
    end else begin
      ready <= 1'b0;
      case (state)
        MUL_IDLE: begin
          if (start) begin
            state <= MUL_RUN;
            bit_cnt <= '0;
          end
        end
        MUL_RUN: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (last) begin
            state <= MUL_IDLE;
            ready <= 1'b1;
          end
        end
        default: state <= MUL_IDLE;
      endcase
    end
  end

  // Operands latched on start, b shifts out MSB first
  always_ff @(posedge CLK) begin
    if (state == MUL_IDLE && start) begin
      mod_q <= modulo;
      a_q <= data_a;
      b_q <= data_b;
      acc <= '0;
    end else if (state == MUL_RUN) begin
      acc <= acc_next;
      b_q <= {b_q[`MR_DATA_W-2:0], 1'b0};
      if (last) begin
        data_out <= acc_next;
      end
    end
  end

  // Partial product stays a residue throughout the run
  assert property (@(posedge CLK) disable iff (RST)
    (state == MUL_RUN) |-> (acc < mod_q));

endmodule

//--- hdl/matrix_store.sv
/*
 * Matrix element store, 4 by 4 residues
 * Row-major streaming loader, combinational read port, write-back port
 */
`timescale 1ns/1ps
`include "matrix_rank_defs.svh"

module matrix_store (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  mr_arith_pkg::value_t size_i,
  input  mr_arith_pkg::value_t size_j,
  input  mr_arith_pkg::value_t data_in,
  input  logic                 i_enable,
  input  logic                 j_enable,
  output mr_arith_pkg::dim_t   rows,
  output mr_arith_pkg::dim_t   cols,
  output logic                 load_done,
  input  mr_arith_pkg::idx_t   rd_row,
  input  mr_arith_pkg::idx_t   rd_col,
  output mr_arith_pkg::value_t rd_data,
  input  logic                 wr_en,
  input  mr_arith_pkg::idx_t   wr_row,
  input  mr_arith_pkg::idx_t   wr_col,
  input  mr_arith_pkg::value_t wr_data
);
  import mr_arith_pkg::*;

  value_t mem [`MR_MAX_DIM][`MR_MAX_DIM];
  logic   armed;
  idx_t   row_cnt;
  idx_t   col_cnt;
  logic   in_stream;
  logic   take;
  logic   row_end;
  logic   mat_end;

  // Stream has begun once the counters have left the origin
  assign in_stream = armed && (row_cnt != '0 || col_cnt != '0);
  assign take = armed && j_enable;
  assign row_end = (dim_t'(col_cnt) == cols - dim_t'(1));
  assign mat_end = row_end && (dim_t'(row_cnt) == rows - dim_t'(1));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      armed <= 1'b0;
      row_cnt <= '0;
      col_cnt <= '0;
      rows <= '0;
      cols <= '0;
      load_done <= 1'b0;
    end else begin
      load_done <= 1'b0;
      if (start && !in_stream) begin
        armed <= 1'b1;
        row_cnt <= '0;
        col_cnt <= '0;
        rows <= size_i[`MR_DIM_W-1:0];
        cols <= size_j[`MR_DIM_W-1:0];
      end else if (take) begin
        if (row_end) begin
          col_cnt <= '0;
          row_cnt <= row_cnt + 1'b1;
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
        // Last element (rows-1, cols-1)
        if (mat_end) begin
          armed <= 1'b0;
          row_cnt <= '0;
          load_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (take) begin
      mem[row_cnt][col_cnt] <= data_in;
    end else if (wr_en) begin
      mem[wr_row][wr_col] <= wr_data;
    end
  end

  assign rd_data = mem[rd_row][rd_col];

  // Host row marker lines up with the column counter
  assert property (@(posedge CLK) disable iff (RST)
    take |-> (i_enable == (col_cnt == '0)));

  // Controller never writes back into a half-loaded matrix
  assert property (@(posedge CLK) disable iff (RST)
    wr_en |-> !in_stream && !take);

endmodule

//--- hdl/matrix_rank.sv
/*
 * Rank engine, fraction-free Gaussian elimination modulo p
 * Pivot search, row update sequencing, rank output
 * Drives one modular multiplier and one modular subtractor
 */
`timescale 1ns/1ps

module matrix_rank (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  mr_arith_pkg::value_t MODULO_IN,
  input  mr_arith_pkg::dim_t   rows,
  input  mr_arith_pkg::dim_t   cols,
  input  logic                 load_done,
  output mr_arith_pkg::idx_t   rd_row,
  output mr_arith_pkg::idx_t   rd_col,
  input  mr_arith_pkg::value_t rd_data,
  output logic                 wr_en,
  output mr_arith_pkg::idx_t   wr_row,
  output mr_arith_pkg::idx_t   wr_col,
  output mr_arith_pkg::value_t wr_data,
  output logic                 READY,
  output mr_arith_pkg::value_t DATA_OUT
);
  import mr_arith_pkg::*;
  import mr_ctrl_pkg::*;

  rank_state_t state;

  // Problem shape and modulus
  value_t    mod_q;
  dim_t      rows_q;
  dim_t      cols_q;

  // Elimination progress
  dim_t      rank_cnt;
  row_mask_t used;
  idx_t      col;
  idx_t      k;
  idx_t      j;
  idx_t      piv_row;

  // Pivot, row factor, first product
  value_t    piv_val;
  value_t    fac;
  value_t    prod_a;

  // Arithmetic handshakes
  logic      mul_start;
  logic      mul_ready;
  value_t    mul_a;
  value_t    mul_out;
  logic      add_start;
  logic      add_ready;
  value_t    add_out;

  logic      hit;
  logic      last_row;
  logic      last_col;
  logic      last_j;

  // Candidate row k is free and has a nonzero entry in the current column
  assign hit = !used[k] && (rd_data != '0);
  assign last_row = (dim_t'(k) == rows_q - dim_t'(1));
  assign last_col = (dim_t'(col) == cols_q - dim_t'(1));
  assign last_j = (dim_t'(j) == cols_q - dim_t'(1));

  ////////////////////
  // Store access
  ////////////////////

  // MUL_B reads the pivot row, MUL_A the target row
  always_comb begin
    rd_row = (state == ST_MUL_B) ? piv_row : k;
    rd_col = (state == ST_MUL_A || state == ST_MUL_B) ? j : col;
  end

  always_comb begin
    wr_en = 1'b0;
    wr_row = k;
    wr_col = j;
    wr_data = add_out;
    if (state == ST_WRITE) begin
      wr_en = 1'b1;
    end else if (state == ST_CHECK_ROW && hit) begin
      // Eliminated entry in pivot column becomes zero
      wr_en = 1'b1;
      wr_col = col;
      wr_data = '0;
    end
  end

  // piv * a[k][j] first, then a[k][col] * a[piv][j]
  assign mul_a = (state == ST_MUL_B) ? fac : piv_val;

  ////////////////////
  // Controller FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ST_IDLE;
      col <= '0;
      k <= '0;
      j <= '0;
      used <= '0;
      rank_cnt <= '0;
      mul_start <= 1'b0;
      add_start <= 1'b0;
      READY <= 1'b0;
      DATA_OUT <= '0;
    end else begin
      mul_start <= 1'b0;
      add_start <= 1'b0;
      READY <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (START) begin
            state <= ST_LOAD;
          end
        end
        ST_LOAD: begin
          if (load_done) begin
            col <= '0;
            k <= '0;
            used <= '0;
            rank_cnt <= '0;
            state <= ST_FIND_PIVOT;
          end
        end
        // First free row with nonzero entry becomes pivot
        ST_FIND_PIVOT: begin
          if (hit) begin
            used[k] <= 1'b1;
            rank_cnt <= rank_cnt + 1'b1;
            k <= '0;
            state <= ST_CHECK_ROW;
          end else if (last_row) begin
            state <= ST_NEXT_COL;
          end else begin
            k <= k + 1'b1;
          end
        end
        // Rows needing elimination, later columns only
        ST_CHECK_ROW: begin
          if (hit && !last_col) begin
            j <= col + 1'b1;
            mul_start <= 1'b1;
            state <= ST_MUL_A;
          end else if (last_row) begin
            state <= ST_NEXT_COL;
          end else begin
            k <= k + 1'b1;
          end
        end
        ST_MUL_A: begin
          if (mul_ready) begin
            mul_start <= 1'b1;
            state <= ST_MUL_B;
          end
        end
        ST_MUL_B: begin
          if (mul_ready) begin
            add_start <= 1'b1;
            state <= ST_SUBTRACT;
          end
        end
        ST_SUBTRACT: begin
          if (add_ready) begin
            state <= ST_WRITE;
          end
        end
        ST_WRITE: begin
          if (!last_j) begin
            j <= j + 1'b1;
            mul_start <= 1'b1;
            state <= ST_MUL_A;
          end else if (last_row) begin
            state <= ST_NEXT_COL;
          end else begin
            k <= k + 1'b1;
            state <= ST_CHECK_ROW;
          end
        end
        // Full row rank reached early or columns used up
        ST_NEXT_COL: begin
          if (rank_cnt == rows_q || last_col) begin
            state <= ST_DONE;
          end else begin
            col <= col + 1'b1;
            k <= '0;
            state <= ST_FIND_PIVOT;
          end
        end
        ST_DONE: begin
          READY <= 1'b1;
          DATA_OUT <= value_t'(rank_cnt);
          state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Operand and pivot registers
  always_ff @(posedge CLK) begin
    if (state == ST_IDLE && START) begin
      mod_q <= MODULO_IN;
    end
    if (state == ST_LOAD && load_done) begin
      rows_q <= rows;
      cols_q <= cols;
    end
    if (state == ST_FIND_PIVOT && hit) begin
      piv_row <= k;
      piv_val <= rd_data;
    end
    if (state == ST_CHECK_ROW && hit) begin
      fac <= rd_data;
    end
    if (state == ST_MUL_A && mul_ready) begin
      prod_a <= mul_out;
    end
  end

  ////////////////////
  // Arithmetic units
  ////////////////////

  mod_multiplier mod_multiplier_i (
    .CLK      (CLK),
    .RST      (RST),
    .start    (mul_start),
    .modulo   (mod_q),
    .data_a   (mul_a),
    .data_b   (rd_data),
    .ready    (mul_ready),
    .data_out (mul_out)
  );

  // Always subtracting, second product is held at mul_out
  mod_adder mod_adder_i (
    .CLK       (CLK),
    .RST       (RST),
    .start     (add_start),
    .operation (1'b1),
    .modulo    (mod_q),
    .data_a    (prod_a),
    .data_b    (mul_out),
    .ready     (add_ready),
    .data_out  (add_out)
  );

  // Every pivot uses up one row and one column
  assert property (@(posedge CLK) disable iff (RST)
    READY |-> (DATA_OUT <= value_t'(rows_q)) && (DATA_OUT <= value_t'(cols_q)));

endmodule

//--- hdl/matrix_rank_unit.sv
/*
 * Top level of the rank subsystem
 * Element store joined to the elimination engine
 */
`timescale 1ns/1ps

module matrix_rank_unit (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  mr_arith_pkg::value_t MODULO_IN,
  input  mr_arith_pkg::value_t SIZE_I_IN,
  input  mr_arith_pkg::value_t SIZE_J_IN,
  input  mr_arith_pkg::value_t DATA_IN,
  input  logic                 DATA_IN_I_ENABLE,
  input  logic                 DATA_IN_J_ENABLE,
  output logic                 READY,
  output mr_arith_pkg::value_t DATA_OUT
);
  import mr_arith_pkg::*;

  // Store to engine
  dim_t   rows;
  dim_t   cols;
  logic   load_done;
  value_t rd_data;

  // Engine to store
  idx_t   rd_row;
  idx_t   rd_col;
  logic   wr_en;
  idx_t   wr_row;
  idx_t   wr_col;
  value_t wr_data;

  matrix_store matrix_store_i (
    .CLK       (CLK),
    .RST       (RST),
    .start     (START),
    .size_i    (SIZE_I_IN),
    .size_j    (SIZE_J_IN),
    .data_in   (DATA_IN),
    .i_enable  (DATA_IN_I_ENABLE),
    .j_enable  (DATA_IN_J_ENABLE),
    .rows      (rows),
    .cols      (cols),
    .load_done (load_done),
    .rd_row    (rd_row),
    .rd_col    (rd_col),
    .rd_data   (rd_data),
    .wr_en     (wr_en),
    .wr_row    (wr_row),
    .wr_col    (wr_col),
    .wr_data   (wr_data)
  );

  matrix_rank matrix_rank_i (
    .CLK       (CLK),
    .RST       (RST),
    .START     (START),
    .MODULO_IN (MODULO_IN),
    .rows      (rows),
    .cols      (cols),
    .load_done (load_done),
    .rd_row    (rd_row),
    .rd_col    (rd_col),
    .rd_data   (rd_data),
    .wr_en     (wr_en),
    .wr_row    (wr_row),
    .wr_col    (wr_col),
    .wr_data   (wr_data),
    .READY     (READY),
    .DATA_OUT  (DATA_OUT)
  );

endmodule

//--- verification/tb_matrix_rank.sv
/*
 * Self-checking testbench for the matrix rank subsystem
 * LFSR stimulus, reference rank model with modular inverses
 * Directed cases for zero, rank-one, dependent rows, mod 7 and busy START
 */
`timescale 1ns/1ps
`include "matrix_rank_defs.svh"

module tb_matrix_rank;
  import mr_arith_pkg::*;

  localparam int N_RANDOM = 40;
  localparam int N_DIRECTED = 9;
  localparam int N_TESTS = N_RANDOM + N_DIRECTED;
  // Worst-case cycles for one matrix, with margin
  localparam int TEST_CYCLES = (16 + 16 * `MR_MUL_CYCLES + 10) * 3;
  localparam int DRIVE_DLY = 1;

  logic   CLK = 1'b0;
  logic   RST;
  logic   START;
  value_t MODULO_IN;
  value_t SIZE_I_IN;
  value_t SIZE_J_IN;
  value_t DATA_IN;
  logic   DATA_IN_I_ENABLE;
  logic   DATA_IN_J_ENABLE;
  logic   READY;
  value_t DATA_OUT;

  logic [15:0]     lfsr_q = 16'd24799;
  longint unsigned mat [4][4];
  value_t          held_out = '0;
  int              checks = 0;
  int              value_errors = 0;
  int              other_errors = 0;

  matrix_rank_unit i_matrix_rank_unit (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .MODULO_IN        (MODULO_IN),
    .SIZE_I_IN        (SIZE_I_IN),
    .SIZE_J_IN        (SIZE_J_IN),
    .DATA_IN          (DATA_IN),
    .DATA_IN_I_ENABLE (DATA_IN_I_ENABLE),
    .DATA_IN_J_ENABLE (DATA_IN_J_ENABLE),
    .READY            (READY),
    .DATA_OUT         (DATA_OUT)
  );

  // 8 ns clock
  always #4 CLK = ~CLK;

  ////////////////////
  // Random source
  ////////////////////

  // Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic int unsigned take_bits(input int n);
    int unsigned v;
    logic        fb;
    v = 0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v = (v << 1) | fb;
    end
    return v;
  endfunction

  function automatic int unsigned pick_prime();
    int unsigned sel;
    sel = take_bits(4) % 3;
    if (sel == 0) begin
      return 7;
    end else if (sel == 1) begin
      return 251;
    end
    return 32749;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  // b^e mod p by square and multiply
  function automatic longint unsigned mod_pow(input longint unsigned b,
                                              input longint unsigned e,
                                              input longint unsigned p);
    longint unsigned r;
    longint unsigned x;
    longint unsigned k;
    r = 1;
    x = b % p;
    k = e;
    while (k != 0) begin
      if ((k & 1) != 0) begin
        r = (r * x) % p;
      end
      x = (x * x) % p;
      k = k >> 1;
    end
    return r;
  endfunction

  // Gauss-Jordan with row swaps, pivot scaled by its Fermat inverse
  function automatic int model_rank(input int rows, input int cols,
                                    input longint unsigned p);
    longint unsigned a [4][4];
    longint unsigned tmp;
    longint unsigned inv;
    longint unsigned f;
    int              r;
    int              piv;
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        a[i][j] = mat[i][j] % p;
      end
    end
    r = 0;
    for (int c = 0; c < cols; c++) begin
      piv = -1;
      for (int i = rows - 1; i >= r; i--) begin
        if (a[i][c] != 0) begin
          piv = i;
        end
      end
      if (piv >= 0) begin
        for (int j = 0; j < cols; j++) begin
          tmp = a[piv][j];
          a[piv][j] = a[r][j];
          a[r][j] = tmp;
        end
        inv = mod_pow(a[r][c], p - 2, p);
        for (int j = 0; j < cols; j++) begin
          a[r][j] = (a[r][j] * inv) % p;
        end
        // Clear the column in every other row
        for (int i = 0; i < rows; i++) begin
          if (i != r && a[i][c] != 0) begin
            f = a[i][c];
            for (int j = 0; j < cols; j++) begin
              a[i][j] = (a[i][j] + p - (f * a[r][j]) % p) % p;
            end
          end
        end
        r++;
      end
    end
    return r;
  endfunction

  ////////////////////
  // Matrix builders
  ////////////////////

  task automatic clear_matrix();
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        mat[i][j] = 0;
      end
    end
  endtask

  // About one entry in four forced to zero
  task automatic fill_random(input int rows, input int cols, input longint unsigned p);
    clear_matrix();
    for (int i = 0; i < rows; i++) begin
      for (int j = 0; j < cols; j++) begin
        if (take_bits(2) == 0) begin
          mat[i][j] = 0;
        end else begin
          mat[i][j] = take_bits(16) % p;
        end
      end
    end
  endtask

  // Row r is (r+1) times row 0
  task automatic fill_multiples(input int rows, input longint unsigned p);
    clear_matrix();
    mat[0][0] = 1;
    for (int j = 1; j < 4; j++) begin
      mat[0][j] = take_bits(16) % p;
    end
    for (int i = 1; i < rows; i++) begin
      for (int j = 0; j < 4; j++) begin
        mat[i][j] = (mat[0][j] * (i + 1)) % p;
      end
    end
  endtask

  // Unit upper triangular rows, last row the sum of the two before it
  task automatic fill_dependent(input int rows, input longint unsigned p);
    clear_matrix();
    for (int i = 0; i < rows - 1; i++) begin
      for (int j = 0; j < 4; j++) begin
        if (j == i) begin
          mat[i][j] = 1;
        end else if (j > i) begin
          mat[i][j] = take_bits(16) % p;
        end
      end
    end
    for (int j = 0; j < 4; j++) begin
      mat[rows-1][j] = (mat[rows-2][j] + mat[rows-3][j]) % p;
    end
  endtask

  ////////////////////
  // Drive and check
  ////////////////////

  // READY low and rank held between strobes
  task automatic check_quiet();
    assert (!READY) else begin
      value_errors++;
      $display("FAIL t=%0t READY got %0b expected 0", $time, READY);
    end
    assert (DATA_OUT == held_out) else begin
      value_errors++;
      $display("FAIL t=%0t DATA_OUT got %0d expected %0d (held)",
               $time, DATA_OUT, held_out);
    end
  endtask

  // START strobe, then row-major elements with occasional idle cycles
  task automatic load_matrix(input int rows, input int cols, input longint unsigned p);
    @(posedge CLK);
    #DRIVE_DLY;
    START = 1'b1;
    MODULO_IN = value_t'(p);
    SIZE_I_IN = value_t'(rows);
    SIZE_J_IN = value_t'(cols);
    @(posedge CLK);
    #DRIVE_DLY;
    START = 1'b0;
    for (int i = 0; i < rows; i++) begin
      for (int j = 0; j < cols; j++) begin
        DATA_IN = value_t'(mat[i][j]);
        DATA_IN_J_ENABLE = 1'b1;
        DATA_IN_I_ENABLE = (j == 0);
        @(posedge CLK);
        #DRIVE_DLY;
        check_quiet();
        DATA_IN_J_ENABLE = 1'b0;
        DATA_IN_I_ENABLE = 1'b0;
        if (take_bits(2) == 0) begin
          @(posedge CLK);
          #DRIVE_DLY;
        end
      end
    end
  endtask

  // Wait for READY, compare, then watch for stray strobes
  task automatic check_rank(input int expected, input int window);
    int n;
    bit seen;
    n = 0;
    seen = 1'b0;
    while (!seen && n < TEST_CYCLES) begin
      @(negedge CLK);
      n++;
      if (READY) begin
        seen = 1'b1;
      end else begin
        // Rank output holds between strobes
        assert (DATA_OUT == held_out) else begin
          value_errors++;
          $display("FAIL t=%0t DATA_OUT got %0d expected %0d (held)",
                   $time, DATA_OUT, held_out);
        end
      end
    end
    if (!seen) begin
      other_errors++;
      $display("Timeout at %0t: no READY within %0d cycles of the load", $time, TEST_CYCLES);
    end else begin
      checks++;
      assert (DATA_OUT == value_t'(expected)) else begin
        value_errors++;
        $display("FAIL t=%0t DATA_OUT got %0d expected %0d", $time, DATA_OUT, expected);
      end
      held_out = value_t'(expected);
      repeat (window) begin
        @(negedge CLK);
        check_quiet();
      end
    end
  endtask

  // One matrix end to end, expected < 0 means trust the model alone
  task automatic run_case(input int rows, input int cols, input longint unsigned p,
                          input int expected, input bit busy_start);
    int model;
    model = model_rank(rows, cols, p);
    if (expected >= 0) begin
      assert (model == expected) else begin
        other_errors++;
        $display("Reference model gives rank %0d for a case built to have rank %0d",
                 model, expected);
      end
    end
    load_matrix(rows, cols, p);
    if (busy_start) begin
      // Lands while the engine is eliminating, different operands
      @(posedge CLK);
      #DRIVE_DLY;
      START = 1'b1;
      MODULO_IN = 7;
      SIZE_I_IN = 1;
      SIZE_J_IN = 1;
      @(posedge CLK);
      #DRIVE_DLY;
      START = 1'b0;
    end
    check_rank(model, busy_start ? 60 : 2);
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    int              rows;
    int              cols;
    longint unsigned p;
    RST = 1'b1;
    START = 1'b0;
    MODULO_IN = '0;
    SIZE_I_IN = '0;
    SIZE_J_IN = '0;
    DATA_IN = '0;
    DATA_IN_I_ENABLE = 1'b0;
    DATA_IN_J_ENABLE = 1'b0;
    repeat (4) @(posedge CLK);
    #DRIVE_DLY;
    RST = 1'b0;

    // Quiet outputs after reset, rank still zero
    repeat (10) begin
      @(negedge CLK);
      check_quiet();
    end

    // Zero matrix and rank-one matrix
    clear_matrix();
    run_case(3, 4, 251, 0, 1'b0);
    fill_multiples(4, 251);
    run_case(4, 4, 251, 1, 1'b0);

    // One row is the sum of two others
    fill_dependent(3, 32749);
    run_case(3, 4, 32749, 2, 1'b0);
    fill_dependent(4, 251);
    run_case(4, 4, 251, 3, 1'b0);

    // Singular only mod 7, det = -7
    clear_matrix();
    mat[0][0] = 1;
    mat[0][1] = 2;
    mat[1][0] = 4;
    mat[1][1] = 1;
    run_case(2, 2, 7, 1, 1'b0);

    // Integer rank 3, rank 2 mod 7
    clear_matrix();
    mat[0][0] = 1;
    mat[0][1] = 2;
    mat[0][2] = 3;
    mat[1][0] = 4;
    mat[1][1] = 1;
    mat[1][2] = 6;
    mat[2][2] = 5;
    run_case(3, 3, 7, 2, 1'b0);

    // Single row and single column shapes
    p = pick_prime();
    fill_random(1, 4, p);
    run_case(1, 4, p, -1, 1'b0);
    p = pick_prime();
    fill_random(4, 1, p);
    run_case(4, 1, p, -1, 1'b0);

    // Second START while busy
    fill_random(4, 4, 32749);
    run_case(4, 4, 32749, -1, 1'b1);

    for (int t = 0; t < N_RANDOM; t++) begin
      rows = take_bits(2) + 1;
      cols = take_bits(2) + 1;
      p = pick_prime();
      fill_random(rows, cols, p);
      run_case(rows, cols, p, -1, 1'b0);
    end

    $display("Rank checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog, bound scales with the number of matrices
  initial begin
    repeat (N_TESTS * TEST_CYCLES) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, run stopped", N_TESTS * TEST_CYCLES);
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- matrix_rank.f
+incdir+hdl
hdl/mr_arith_pkg.sv
hdl/mr_ctrl_pkg.sv
hdl/mod_adder.sv
hdl/mod_multiplier.sv
hdl/matrix_store.sv
hdl/matrix_rank.sv
hdl/matrix_rank_unit.sv
verification/tb_matrix_rank.sv
